// ==== flist.f ====
ifu_pkg.sv
ifu_ctrl.sv
ifu_pc_gen.sv
ifu_branch_predict.sv
ifu_ir_stage.sv
ifu_top.sv
tb_ifu.sv

// ==== ifu_branch_predict.sv ====
`timescale 1ns/1ps

module ifu_branch_predict (
	input  ifu_pkg::instr_t instr,
	input  logic            rsp_valid,
	output logic            bjp_taken,
	output ifu_pkg::pc_t    bjp_offset
);

	logic         dec_jal;
	logic         dec_bxx;
	ifu_pkg::pc_t j_imm;
	ifu_pkg::pc_t b_imm;

	//////////////////////////////////////////////////
	// Mini-decoder

	// Only the major opcode is needed here
	assign dec_jal = (instr[6:0] == ifu_pkg::OPC_JAL);
	assign dec_bxx = (instr[6:0] == ifu_pkg::OPC_BRANCH);

	// J-type immediate, imm[20|10:1|11|19:12]
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	// B-type immediate, imm[12|10:5] and imm[4:1|11]
	assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

	assign bjp_offset = dec_jal ? j_imm : b_imm;

	//////////////////////////////////////////////////
	// Static prediction

	// JAL always taken
	// Conditional branch taken when backward, sign bit is instr[31]
	assign bjp_taken = rsp_valid & (dec_jal | (dec_bxx & instr[31]));

endmodule

// ==== ifu_ctrl.sv ====
`timescale 1ns/1ps

module ifu_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic halt_req,
	output logic halt_ack,
	input  logic flush_req,
	output logic flush_ack,
	output logic req_valid,
	input  logic req_ready,
	input  logic rsp_valid,
	output logic rsp_ready,
	input  logic o_valid,
	input  logic o_ready,
	output logic reset_req,
	output logic flush_pending,
	output logic pc_ena,
	output logic ir_load,
	output logic pc_load,
	output logic ir_kill
);

	logic req_hsk;
	logic rsp_hsk;
	logic o_hsk;
	logic reset_flag;
	logic out_flag;
	logic dly_flush;
	logic pc_newpend;
	logic flush_real;
	logic ir_clr;
	logic ir_ready;
	logic no_outs;
	logic new_req;
	logic req_valid_pre;

	// Handshakes on the three channels
	assign req_hsk = req_valid & req_ready;
	assign rsp_hsk = rsp_valid & rsp_ready;
	assign o_hsk   = o_valid & o_ready;

	// Flush is always taken and a missed redirect goes to the delayed flag
	assign flush_ack  = 1'b1;
	assign flush_real = flush_req | dly_flush;

	//////////////////////////////////////////////////
	// Control flags

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_flag <= 1'b1;
			reset_req  <= 1'b0;
			out_flag   <= 1'b0;
			halt_ack   <= 1'b0;
			dly_flush  <= 1'b0;
			pc_newpend <= 1'b0;
		end else begin
			// Held only for the first cycle out of reset
			reset_flag <= 1'b0;
			// Reset fetch stays requested until it is accepted
			if (reset_flag & ~reset_req) begin
				reset_req <= 1'b1;
			end else if (reset_req & req_hsk) begin
				reset_req <= 1'b0;
			end
			// Outstanding request where a new request wins over the returning response
			if (req_hsk) begin
				out_flag <= 1'b1;
			end else if (rsp_hsk) begin
				out_flag <= 1'b0;
			end
			// Ack once nothing is in flight
			if (halt_req & ~halt_ack & no_outs) begin
				halt_ack <= 1'b1;
			end else if (halt_ack & ~halt_req) begin
				halt_ack <= 1'b0;
			end
			// Redirect that could not issue in the flush cycle
			if (flush_req & ~req_hsk) begin
				dly_flush <= 1'b1;
			end else if (dly_flush & req_hsk) begin
				dly_flush <= 1'b0;
			end
			// New PC loaded but not yet copied to the IR-PC register
			if (pc_ena) begin
				pc_newpend <= 1'b1;
			end else if (pc_load) begin
				pc_newpend <= 1'b0;
			end
		end
	end

	assign flush_pending = dly_flush;

	// A valid response also counts as drained since it only waits for the release
	assign no_outs = ~out_flag | rsp_valid;

	//////////////////////////////////////////////////
	// Request and response channel

	// IR can take a word when empty or leaving this cycle
	assign ir_clr   = o_hsk | (flush_req & o_valid);
	assign ir_ready = ~o_valid | ir_clr;

	// Sequential fetch stops on halt and in the first cycle out of reset
	assign new_req       = ~halt_req & ~reset_flag;
	assign req_valid_pre = new_req | reset_req | flush_real;

	// One outstanding request only; a response frees the slot in the same cycle
	assign req_valid = req_valid_pre & (~out_flag | rsp_hsk);

	// Flushed responses are dropped at once
	// Otherwise the follow-up request must be able to go out too
	// Under halt the response waits on the bus and keeps its prediction
	assign rsp_ready = flush_real | (ir_ready & req_ready & ~halt_req);

	// PC follows every request and every flush target
	assign pc_ena = req_hsk | flush_req;

	// IR strobes toward the execute side
	assign ir_load = rsp_hsk & ~flush_real;
	assign pc_load = pc_newpend & ir_ready & ~flush_real;
	assign ir_kill = flush_req;

	//////////////////////////////////////////////////
	// Checks

	a_req_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(req_valid));

	// A waiting request is only withdrawn by a halt
	a_req_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(req_valid && !req_ready) |=> (req_valid || halt_req));

endmodule

// ==== ifu_ir_stage.sv ====
`timescale 1ns/1ps

module ifu_ir_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  ifu_pkg::instr_t rsp_instr,
	input  logic            rsp_err,
	input  logic            bjp_taken,
	input  ifu_pkg::pc_t    pc,
	input  logic            ir_load,
	input  logic            pc_load,
	input  logic            ir_kill,
	input  logic            o_ready,
	output logic            o_valid,
	output logic            o_pc_vld,
	output ifu_pkg::instr_t o_ir,
	output ifu_pkg::pc_t    o_pc,
	output logic            o_buserr,
	output logic            o_prdt_taken
);

	logic ir_clr;

	// Leaves on the execute handshake or is dropped by a flush
	assign ir_clr = (o_valid & o_ready) | (ir_kill & o_valid);

	//////////////////////////////////////////////////
	// Valid flags

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_valid  <= 1'b0;
			o_pc_vld <= 1'b0;
		end else begin
			// Load wins when the next word arrives as the old one leaves
			if (ir_load) begin
				o_valid <= 1'b1;
			end else if (ir_clr) begin
				o_valid <= 1'b0;
			end
			if (pc_load) begin
				o_pc_vld <= 1'b1;
			end else if (ir_clr) begin
				o_pc_vld <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Data registers

	// Instruction, bus error and prediction come with the response
	always_ff @(posedge clk) begin
		if (ir_load) begin
			o_ir         <= rsp_instr;
			o_buserr     <= rsp_err;
			o_prdt_taken <= bjp_taken;
		end
	end

	// PC may land before its instruction returns
	always_ff @(posedge clk) begin
		if (pc_load) begin
			o_pc <= pc;
		end
	end

	//////////////////////////////////////////////////
	// Checks

	// Response back-pressure in the controller keeps the IR frozen
	a_ir_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(o_valid && !o_ready) |=> $stable(o_ir));

endmodule

// ==== ifu_pc_gen.sv ====
`timescale 1ns/1ps

module ifu_pc_gen (
	input  logic          clk,
	input  logic          rst_n,
	input  ifu_pkg::pc_t  rst_vec,
	input  logic          flush_req,
	input  ifu_pkg::pc_t  flush_op1,
	input  ifu_pkg::pc_t  flush_op2,
	input  logic          reset_req,
	input  logic          flush_pending,
	input  logic          bjp_taken,
	input  ifu_pkg::pc_t  bjp_offset,
	input  logic          pc_ena,
	output ifu_pkg::pc_t  pc,
	output ifu_pkg::pc_t  req_pc
);

	ifu_pkg::pc_t add_op1;
	ifu_pkg::pc_t add_op2;
	ifu_pkg::pc_t pc_sum;

	//////////////////////////////////////////////////
	// Adder operand select

	always_comb begin
		if (flush_req) begin
			// Redirect from execute
			add_op1 = flush_op1;
			add_op2 = flush_op2;
		end else if (flush_pending) begin
			// PC already holds the flush target
			add_op1 = pc;
			add_op2 = '0;
		end else if (bjp_taken) begin
			// PC still points at the returning instruction
			add_op1 = pc;
			add_op2 = bjp_offset;
		end else if (reset_req) begin
			add_op1 = rst_vec;
			add_op2 = '0;
		end else begin
			add_op1 = pc;
			add_op2 = ifu_pkg::PC_STEP;
		end
	end

	// One shared adder for all sources
	assign pc_sum = add_op1 + add_op2;

	// Halfword aligned, as for a JALR target
	assign req_pc = {pc_sum[31:1], 1'b0};

	//////////////////////////////////////////////////
	// PC register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (pc_ena) begin
			pc <= req_pc;
		end
	end

endmodule

// ==== ifu_pkg.sv ====
package ifu_pkg;

	//////////////////////////////////////////////////
	// Widths fixed by RV32

	// Fetch address, byte granular
	typedef logic [31:0] pc_t;

	// One 32-bit instruction word as returned by memory
	typedef logic [31:0] instr_t;

	//////////////////////////////////////////////////
	// Major opcodes seen by the mini-decoder

	// JAL, unconditional jump with a J-type immediate
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	// BEQ/BNE/BLT/BGE/BLTU/BGEU share this major opcode
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	//////////////////////////////////////////////////
	// Sequential fetch

	// No compressed support, so every step is one full word
	localparam pc_t PC_STEP = 32'd4;

endpackage

// ==== ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top (
	input  logic            clk,
	input  logic            rst_n,
	input  ifu_pkg::pc_t    rst_vec,
	// Fetch request
	output logic            req_valid,
	input  logic            req_ready,
	output ifu_pkg::pc_t    req_pc,
	// Fetch response
	input  logic            rsp_valid,
	output logic            rsp_ready,
	input  ifu_pkg::instr_t rsp_instr,
	input  logic            rsp_err,
	// Toward execute
	output logic            o_valid,
	input  logic            o_ready,
	output ifu_pkg::instr_t o_ir,
	output ifu_pkg::pc_t    o_pc,
	output logic            o_pc_vld,
	output logic            o_buserr,
	output logic            o_prdt_taken,
	// Pipeline flush
	input  logic            flush_req,
	output logic            flush_ack,
	input  ifu_pkg::pc_t    flush_op1,
	input  ifu_pkg::pc_t    flush_op2,
	// Halt
	input  logic            halt_req,
	output logic            halt_ack
);

	logic         reset_req;
	logic         flush_pending;
	logic         pc_ena;
	logic         ir_load;
	logic         pc_load;
	logic         ir_kill;
	logic         bjp_taken;
	ifu_pkg::pc_t bjp_offset;
	ifu_pkg::pc_t pc;

	//////////////////////////////////////////////////
	// Flags and handshakes
	ifu_ctrl i_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.halt_req      (halt_req),
		.halt_ack      (halt_ack),
		.flush_req     (flush_req),
		.flush_ack     (flush_ack),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.o_valid       (o_valid),
		.o_ready       (o_ready),
		.reset_req     (reset_req),
		.flush_pending (flush_pending),
		.pc_ena        (pc_ena),
		.ir_load       (ir_load),
		.pc_load       (pc_load),
		.ir_kill       (ir_kill)
	);

	// Next PC
	ifu_pc_gen i_pc_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.rst_vec       (rst_vec),
		.flush_req     (flush_req),
		.flush_op1     (flush_op1),
		.flush_op2     (flush_op2),
		.reset_req     (reset_req),
		.flush_pending (flush_pending),
		.bjp_taken     (bjp_taken),
		.bjp_offset    (bjp_offset),
		.pc_ena        (pc_ena),
		.pc            (pc),
		.req_pc        (req_pc)
	);

	// Prediction straight off the response bus
	ifu_branch_predict i_bp (
		.instr      (rsp_instr),
		.rsp_valid  (rsp_valid),
		.bjp_taken  (bjp_taken),
		.bjp_offset (bjp_offset)
	);

	//////////////////////////////////////////////////
	// IR toward execute
	ifu_ir_stage i_ir (
		.clk          (clk),
		.rst_n        (rst_n),
		.rsp_instr    (rsp_instr),
		.rsp_err      (rsp_err),
		.bjp_taken    (bjp_taken),
		.pc           (pc),
		.ir_load      (ir_load),
		.pc_load      (pc_load),
		.ir_kill      (ir_kill),
		.o_ready      (o_ready),
		.o_valid      (o_valid),
		.o_pc_vld     (o_pc_vld),
		.o_ir         (o_ir),
		.o_pc         (o_pc),
		.o_buserr     (o_buserr),
		.o_prdt_taken (o_prdt_taken)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the IFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_ifu -o sim_ifu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_ifu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
	exit 0
fi
exit 1

// ==== tb_ifu.sv ====
`timescale 1ns/1ps

module tb_ifu;

	localparam int N_TESTS = 6;
	localparam int CYC_PER_TEST = 200;
	localparam ifu_pkg::pc_t RST_VEC = 32'h0000_0100;

	logic clk = 1'b0;
	logic rst_n;
	ifu_pkg::pc_t rst_vec;
	logic req_valid;
	logic req_ready;
	ifu_pkg::pc_t req_pc;
	logic rsp_valid;
	logic rsp_ready;
	ifu_pkg::instr_t rsp_instr;
	logic rsp_err;
	logic o_valid;
	logic o_ready;
	ifu_pkg::instr_t o_ir;
	ifu_pkg::pc_t o_pc;
	logic o_pc_vld;
	logic o_buserr;
	logic o_prdt_taken;
	logic flush_req;
	logic flush_ack;
	ifu_pkg::pc_t flush_op1;
	ifu_pkg::pc_t flush_op2;
	logic halt_req;
	logic halt_ack;

	// Run state shared between stimulus, memory and checker
	string cur_test = "reset_fetch";
	int chk_errs = 0;
	int stim_errs = 0;
	int n_fail_tests = 0;
	int n_out = 0;
	int n_err_seen = 0;
	logic rand_ready = 1'b1;
	logic err_on = 1'b0;
	logic bp_mode = 1'b0;
	ifu_pkg::pc_t exp_pc = RST_VEC;
	ifu_pkg::instr_t last_instr [ifu_pkg::pc_t];
	logic last_err [ifu_pkg::pc_t];
	bit visited [ifu_pkg::pc_t];

	ifu_top i_ifu_top (.*);

	always #20 clk = ~clk;

	//////////////////////////////////////////////////
	// Memory contents and reference model

	// JAL +16 on bits 5:4 = 01, BNE -8 on 10 the first time only, ALU word elsewhere
	function automatic ifu_pkg::instr_t mem_word(input ifu_pkg::pc_t a, input logic first);
		logic [11:0] imm;
		imm = a[11:0] ^ a[23:12] ^ {4'd0, a[31:24]};
		mem_word = {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
		if (a[5:4] == 2'b01)
			mem_word = {1'b0, 10'd8, 1'b0, 8'd0, 5'd1, 7'b1101111};
		else if (a[5:4] == 2'b10 && first)
			mem_word = {1'b1, 6'h3f, 5'd0, 5'd0, 3'b001, 4'b1100, 1'b1, 7'b1100011};
	endfunction

	// JAL always, conditional branch only when backward
	function automatic logic taken_ref(input ifu_pkg::instr_t w);
		return (w[6:0] == 7'h6f) || (w[6:0] == 7'h63 && w[31]);
	endfunction

	function automatic ifu_pkg::pc_t next_pc_ref(input ifu_pkg::pc_t p, input ifu_pkg::instr_t w);
		ifu_pkg::pc_t off;
		ifu_pkg::pc_t n;
		if (w[6:0] == 7'h6f)
			off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		else
			off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		n = taken_ref(w) ? p + off : p + 32'd4;
		return {n[31:1], 1'b0};
	endfunction

	function automatic int errs();
		return chk_errs + stim_errs;
	endfunction

	//////////////////////////////////////////////////
	// Memory responder with 0 to 3 cycles of latency

	initial begin
		logic req_fire;
		logic rsp_fire;
		ifu_pkg::pc_t fire_pc;
		ifu_pkg::pc_t addr;
		logic busy;
		int delay;
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp_instr = '0;
		rsp_err = 1'b0;
		busy = 1'b0;
		delay = 0;
		addr = '0;
		forever begin
			// Sample at the rising edge, drive at the falling one
			@(posedge clk);
			req_fire = rst_n && req_valid && req_ready;
			rsp_fire = rsp_valid && rsp_ready;
			fire_pc = req_pc;
			@(negedge clk);
			if (rsp_fire) begin
				rsp_valid = 1'b0;
				busy = 1'b0;
			end
			if (req_fire) begin
				busy = 1'b1;
				addr = fire_pc;
				delay = $urandom % 4;
			end
			if (busy && !rsp_valid) begin
				if (delay == 0) begin
					rsp_instr = mem_word(addr, !visited.exists(addr));
					rsp_err = err_on ? ($urandom % 4 == 0) : 1'b0;
					visited[addr] = 1'b1;
					last_instr[addr] = rsp_instr;
					last_err[addr] = rsp_err;
					rsp_valid = 1'b1;
				end else begin
					delay--;
				end
			end
			req_ready = rand_ready ? ($urandom % 4 != 0) : 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Checker on every execute handshake

	always @(posedge clk) begin
		if (rst_n) begin
			if (o_valid && o_ready) begin
				assert (o_pc_vld) else begin
					$display("%s: o_pc_vld low on an execute handshake", cur_test);
					chk_errs++;
				end
				assert (o_pc == exp_pc) else begin
					$display("[FAIL] %s: o_pc expected %h actual %h", cur_test, exp_pc, o_pc);
					chk_errs++;
				end
				assert (o_ir == last_instr[o_pc]) else begin
					$display("[FAIL] %s: o_ir expected %h actual %h", cur_test,
						last_instr[o_pc], o_ir);
					chk_errs++;
				end
				assert (o_buserr == last_err[o_pc]) else begin
					$display("[FAIL] %s: o_buserr expected %b actual %b", cur_test,
						last_err[o_pc], o_buserr);
					chk_errs++;
				end
				assert (o_prdt_taken == taken_ref(o_ir)) else begin
					$display("[FAIL] %s: o_prdt_taken expected %b actual %b", cur_test,
						taken_ref(o_ir), o_prdt_taken);
					chk_errs++;
				end
				exp_pc = next_pc_ref(o_pc, o_ir);
				n_out++;
				if (o_buserr)
					n_err_seen++;
			end
			assert (!(halt_req && req_valid)) else begin
				$display("%s: request raised while halt_req is high", cur_test);
				chk_errs++;
			end
			// Redirect target replaces the predicted flow
			if (flush_req) begin
				assert (flush_ack) else begin
					$display("[FAIL] %s: flush_ack expected 1 actual %b", cur_test, flush_ack);
					chk_errs++;
				end
				exp_pc = (flush_op1 + flush_op2) & ~32'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus

	task automatic wait_outputs(input int n);
		int target;
		int cyc;
		target = n_out + n;
		cyc = 0;
		while (n_out < target && cyc < n * 40) begin
			@(negedge clk);
			o_ready = bp_mode ? ($urandom % 2 == 0) : 1'b1;
			cyc++;
		end
		assert (n_out >= target) else begin
			$display("%s: timed out waiting for %0d instructions", cur_test, n);
			stim_errs++;
		end
	endtask

	task automatic finish_test(input int e0);
		if (errs() != e0)
			n_fail_tests++;
		$display("test %s: %0d errors, %0d instructions so far", cur_test, errs() - e0, n_out);
	endtask

	initial begin
		int e0;
		int k;
		int t;
		void'($urandom(32'he1f3));
		rst_n = 1'b0;
		rst_vec = RST_VEC;
		o_ready = 1'b0;
		flush_req = 1'b0;
		flush_op1 = '0;
		flush_op2 = '0;
		halt_req = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (!req_valid && !o_valid && !o_pc_vld && !halt_ack) else begin
			$display("outputs not idle during reset");
			stim_errs++;
		end
		rst_n = 1'b1;
		e0 = errs();
		wait_outputs(1);
		finish_test(e0);
		cur_test = "seq_flow";
		e0 = errs();
		wait_outputs(30);
		finish_test(e0);
		cur_test = "back_pressure";
		e0 = errs();
		bp_mode = 1'b1;
		wait_outputs(30);
		bp_mode = 1'b0;
		finish_test(e0);
		cur_test = "flush";
		e0 = errs();
		for (k = 0; k < 3; k++) begin
			repeat ($urandom % 4) @(negedge clk);
			flush_op1 = $urandom & 32'h0000_0ffc;
			flush_op2 = $urandom % 16;
			flush_req = 1'b1;
			@(negedge clk);
			flush_req = 1'b0;
			wait_outputs(8);
		end
		finish_test(e0);
		cur_test = "bus_error";
		e0 = errs();
		err_on = 1'b1;
		k = n_err_seen;
		wait_outputs(24);
		err_on = 1'b0;
		assert (n_err_seen > k) else begin
			$display("bus_error: no bus error reached execute");
			stim_errs++;
		end
		finish_test(e0);
		cur_test = "halt";
		e0 = errs();
		repeat (2) begin
			halt_req = 1'b1;
			o_ready = 1'b1;
			rand_ready = 1'b0;
			t = 0;
			while (!halt_ack && t < 20) begin
				@(negedge clk);
				t++;
			end
			assert (halt_ack) else begin
				$display("halt: halt_ack did not rise within 20 cycles");
				stim_errs++;
			end
			// Let the IR drain, then nothing more may arrive
			repeat (3) @(negedge clk);
			k = n_out;
			repeat (8) @(negedge clk);
			assert (n_out == k && !o_valid) else begin
				$display("halt: instruction delivered while halted");
				stim_errs++;
			end
			halt_req = 1'b0;
			@(negedge clk);
			assert (!halt_ack) else begin
				$display("halt: halt_ack still high after release");
				stim_errs++;
			end
			rand_ready = 1'b1;
			wait_outputs(6);
		end
		finish_test(e0);
		$display("tests %0d, failing %0d, instructions %0d, errors %0d",
			N_TESTS, n_fail_tests, n_out, errs());
		if (errs() == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(N_TESTS * CYC_PER_TEST * 40);
		$display("Watchdog expired in test %s", cur_test);
		$display("Simulation FAILED");
		$finish;
	end

endmodule
